// ==== hw/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    localparam int XLEN       = 32; // data and address width
    localparam int REG_ADDR_W = 5;  // 32 architectural registers

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011, // reg-reg alu
        OPC_OP_IMM = 7'b0010011, // reg-imm alu
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011, // request only
        OPC_STORE  = 7'b0100011  // request only
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B // lui
    } alu_op_e;

    // same codes as branch funct3
    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } br_cond_e;

    typedef enum logic [1:0] {
        WB_ALU      = 2'd0,
        WB_PC_PLUS4 = 2'd1, // link value
        WB_MEM      = 2'd2  // load data, not written here
    } wb_sel_e;

    localparam word_t INST_NOP = 32'h0000_0013; // addi x0, x0, 0

endpackage

`default_nettype wire

// ==== hw/inst_decoder.sv ====
`default_nettype none

module inst_decoder (
    input  logic              inst_valid_i,
    input  rv_pkg::word_t     inst_i,
    output logic              valid_o,
    output rv_pkg::opcode_e   opcode_o,
    output logic [2:0]        funct3_o,
    output rv_pkg::alu_op_e   alu_op_o,
    output logic              alu_src1_o,  // pc instead of rs1
    output logic              alu_src2_o,  // imm instead of rs2
    output rv_pkg::wb_sel_e   wb_sel_o,
    output logic              reg_write_o,
    output logic              mem_read_o,
    output logic              mem_write_o,
    output logic              branch_o,
    output logic              jump_o,
    output rv_pkg::reg_addr_t rs1_o,
    output rv_pkg::reg_addr_t rs2_o,
    output rv_pkg::reg_addr_t rd_o,
    output rv_pkg::word_t     offset_o
);
    import rv_pkg::*;

    word_t   inst;  // bubble when no strobe
    word_t   imm_i, imm_s, imm_b, imm_u, imm_j;
    alu_op_e alu_fn; // funct3/funct7 mapping

    assign inst     = inst_valid_i ? inst_i : INST_NOP;
    assign opcode_o = opcode_e'(inst[6:0]);
    assign funct3_o = inst[14:12];
    assign rs1_o    = inst[19:15];
    assign rs2_o    = inst[24:20];
    assign rd_o     = inst[11:7];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        case (inst[14:12])
            3'b000:  alu_fn = (inst[6:0] == OPC_OP && inst[30]) ? ALU_SUB : ALU_ADD; // addi has no sub
            3'b001:  alu_fn = ALU_SLL;
            3'b010:  alu_fn = ALU_SLT;
            3'b011:  alu_fn = ALU_SLTU;
            3'b100:  alu_fn = ALU_XOR;
            3'b101:  alu_fn = inst[30] ? ALU_SRA : ALU_SRL; // funct7[5] or imm[10]
            3'b110:  alu_fn = ALU_OR;
            default: alu_fn = ALU_AND;
        endcase
    end

    always_comb begin
        valid_o     = inst_valid_i;
        alu_op_o    = ALU_ADD;  // address calc default
        alu_src1_o  = 1'b0;
        alu_src2_o  = 1'b1;     // most classes take the imm
        wb_sel_o    = WB_ALU;
        reg_write_o = 1'b0;
        mem_read_o  = 1'b0;
        mem_write_o = 1'b0;
        branch_o    = 1'b0;
        jump_o      = 1'b0;
        offset_o    = imm_i;
        case (opcode_o)
            OPC_OP: begin
                reg_write_o = 1'b1;
                alu_op_o    = alu_fn;
                alu_src2_o  = 1'b0;
            end
            OPC_OP_IMM: begin
                reg_write_o = 1'b1;
                alu_op_o    = alu_fn; // shamt sits in imm[4:0]
            end
            OPC_LUI: begin
                reg_write_o = 1'b1;
                alu_op_o    = ALU_PASS_B;
                offset_o    = imm_u;
            end
            OPC_AUIPC: begin
                reg_write_o = 1'b1;
                alu_src1_o  = 1'b1;
                offset_o    = imm_u;
            end
            OPC_JAL: begin
                reg_write_o = 1'b1;
                jump_o      = 1'b1;
                alu_src1_o  = 1'b1;
                wb_sel_o    = WB_PC_PLUS4;
                offset_o    = imm_j;
            end
            OPC_JALR: begin
                reg_write_o = 1'b1;
                jump_o      = 1'b1;
                wb_sel_o    = WB_PC_PLUS4;
            end
            OPC_BRANCH: begin
                branch_o   = 1'b1;
                alu_op_o   = ALU_SUB;
                alu_src2_o = 1'b0;  // compare rs1 with rs2
                offset_o   = imm_b;
            end
            OPC_LOAD: begin
                mem_read_o = 1'b1;
                wb_sel_o   = WB_MEM; // no rf write in this slice
            end
            OPC_STORE: begin
                mem_write_o = 1'b1;
                offset_o    = imm_s;
            end
            default: valid_o = 1'b0; // unsupported, bubble
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/reg_file.sv ====
`default_nettype none

module reg_file (
    input  logic              clk,
    input  logic              arst_n_i,
    input  rv_pkg::reg_addr_t rs1_i,
    input  rv_pkg::reg_addr_t rs2_i,
    input  rv_pkg::reg_addr_t rd_i,
    input  logic              we_i,
    input  rv_pkg::word_t     wdata_i,
    output rv_pkg::word_t     rdata1_o,
    output rv_pkg::word_t     rdata2_o
);
    import rv_pkg::*;

    word_t regs [1:31]; // x0 not stored

    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;                 // x0 hardwired
        end else if (we_i && addr == rd_i) begin
            return wdata_i;            // write-first bypass
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin // x0 writes dropped
            regs[rd_i] <= wdata_i;
        end
    end

    // re-evaluated on write port and array changes too
    always_comb begin
        rdata1_o = read_port(rs1_i);
        rdata2_o = read_port(rs2_i);
    end

endmodule

`default_nettype wire

// ==== hw/decode_execute_register.sv ====
`default_nettype none

module decode_execute_register (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              flush_i,          // squash the incoming slot
    input  logic              valid_i,
    input  rv_pkg::word_t     pc_i,
    input  rv_pkg::opcode_e   opcode_i,
    input  logic [2:0]        funct3_i,
    input  rv_pkg::alu_op_e   alu_op_i,
    input  logic              alu_src1_i,
    input  logic              alu_src2_i,
    input  rv_pkg::wb_sel_e   wb_sel_i,
    input  logic              reg_write_i,
    input  logic              mem_read_i,
    input  logic              mem_write_i,
    input  logic              branch_i,
    input  logic              jump_i,
    input  rv_pkg::reg_addr_t rs1_i,
    input  rv_pkg::reg_addr_t rs2_i,
    input  rv_pkg::reg_addr_t rd_i,
    input  rv_pkg::word_t     read_data1_i,
    input  rv_pkg::word_t     read_data2_i,
    input  rv_pkg::word_t     offset_i,
    output logic              de_valid_o,
    output rv_pkg::word_t     de_pc_o,
    output rv_pkg::opcode_e   de_opcode_o,
    output logic [2:0]        de_funct3_o,
    output rv_pkg::alu_op_e   de_alu_op_o,
    output logic              de_alu_src1_o,
    output logic              de_alu_src2_o,
    output rv_pkg::wb_sel_e   de_wb_sel_o,
    output logic              de_reg_write_o,
    output logic              de_mem_read_o,
    output logic              de_mem_write_o,
    output logic              de_branch_o,
    output logic              de_jump_o,
    output rv_pkg::reg_addr_t de_rs1_o,
    output rv_pkg::reg_addr_t de_rs2_o,
    output rv_pkg::reg_addr_t de_rd_o,
    output rv_pkg::word_t     de_read_data1_o,
    output rv_pkg::word_t     de_read_data2_o,
    output rv_pkg::word_t     de_offset_o
);

    // valid and side-effect bits, cleared by reset or flush
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            de_valid_o     <= 1'b0;
            de_reg_write_o <= 1'b0;
            de_mem_read_o  <= 1'b0;
            de_mem_write_o <= 1'b0;
            de_branch_o    <= 1'b0;
            de_jump_o      <= 1'b0;
        end else begin
            de_valid_o     <= valid_i && !flush_i;
            de_reg_write_o <= reg_write_i && !flush_i;
            de_mem_read_o  <= mem_read_i && !flush_i;
            de_mem_write_o <= mem_write_i && !flush_i;
            de_branch_o    <= branch_i && !flush_i;
            de_jump_o      <= jump_i && !flush_i;
        end
    end

    // payload, qualified downstream by de_valid_o
    always_ff @(posedge clk) begin
        de_pc_o         <= pc_i;
        de_opcode_o     <= opcode_i;
        de_funct3_o     <= funct3_i;
        de_alu_op_o     <= alu_op_i;
        de_alu_src1_o   <= alu_src1_i;
        de_alu_src2_o   <= alu_src2_i;
        de_wb_sel_o     <= wb_sel_i;
        de_rs1_o        <= rs1_i;
        de_rs2_o        <= rs2_i;
        de_rd_o         <= rd_i;
        de_read_data1_o <= read_data1_i;
        de_read_data2_o <= read_data2_i;
        de_offset_o     <= offset_i;
    end

endmodule

`default_nettype wire

// ==== hw/execute_unit.sv ====
`default_nettype none

module execute_unit (
    input  logic              de_valid_i,
    input  rv_pkg::word_t     de_pc_i,
    input  rv_pkg::opcode_e   de_opcode_i,
    input  logic [2:0]        de_funct3_i,     // branch condition
    input  rv_pkg::alu_op_e   de_alu_op_i,
    input  logic              de_alu_src1_i,
    input  logic              de_alu_src2_i,
    input  rv_pkg::wb_sel_e   de_wb_sel_i,
    input  logic              de_reg_write_i,
    input  logic              de_mem_read_i,
    input  logic              de_mem_write_i,
    input  logic              de_branch_i,
    input  logic              de_jump_i,
    input  rv_pkg::reg_addr_t de_rd_i,
    input  rv_pkg::word_t     de_read_data1_i,
    input  rv_pkg::word_t     de_read_data2_i,
    input  rv_pkg::word_t     de_offset_i,
    output rv_pkg::word_t     result_o,
    output logic              rf_we_o,
    output rv_pkg::reg_addr_t rf_waddr_o,
    output logic              mem_read_o,
    output logic              mem_write_o,
    output rv_pkg::word_t     mem_addr_o,
    output rv_pkg::word_t     store_data_o,
    output logic              redirect_o,
    output rv_pkg::word_t     target_o
);
    import rv_pkg::*;

    word_t      op_a, op_b;
    word_t      alu_out;
    word_t      target_sum;
    logic [4:0] shamt;
    logic       is_jalr;
    logic       taken;     // branch condition holds

    assign op_a    = de_alu_src1_i ? de_pc_i : de_read_data1_i;
    assign op_b    = de_alu_src2_i ? de_offset_i : de_read_data2_i;
    assign shamt   = op_b[4:0];
    assign is_jalr = (de_opcode_i == OPC_JALR);

    always_comb begin
        case (de_alu_op_i)
            ALU_ADD:    alu_out = op_a + op_b;
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_SLL:    alu_out = op_a << shamt;
            ALU_SLT:    alu_out = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_out = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_SRL:    alu_out = op_a >> shamt;
            ALU_SRA:    alu_out = word_t'($signed(op_a) >>> shamt);
            ALU_OR:     alu_out = op_a | op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_PASS_B: alu_out = op_b;     // lui
            default:    alu_out = '0;
        endcase
    end

    // comparator always on the two register operands
    always_comb begin
        case (br_cond_e'(de_funct3_i))
            BR_BEQ:  taken = (de_read_data1_i == de_read_data2_i);
            BR_BNE:  taken = (de_read_data1_i != de_read_data2_i);
            BR_BLT:  taken = ($signed(de_read_data1_i) < $signed(de_read_data2_i));
            BR_BGE:  taken = ($signed(de_read_data1_i) >= $signed(de_read_data2_i));
            BR_BLTU: taken = (de_read_data1_i < de_read_data2_i);
            BR_BGEU: taken = (de_read_data1_i >= de_read_data2_i);
            default: taken = 1'b0;   // reserved funct3
        endcase
    end

    assign target_sum = (is_jalr ? de_read_data1_i : de_pc_i) + de_offset_i;
    assign target_o   = is_jalr ? {target_sum[XLEN-1:1], 1'b0} : target_sum;
    assign redirect_o = de_valid_i && (de_jump_i || (de_branch_i && taken));

    assign result_o   = (de_wb_sel_i == WB_PC_PLUS4) ? de_pc_i + 32'd4 : alu_out;
    assign rf_we_o    = de_valid_i && de_reg_write_i && (de_rd_i != '0);
    assign rf_waddr_o = de_rd_i;

    assign mem_read_o   = de_valid_i && de_mem_read_i;
    assign mem_write_o  = de_valid_i && de_mem_write_i;
    assign mem_addr_o   = alu_out;          // rs1 + offset
    assign store_data_o = de_read_data2_i;

endmodule

`default_nettype wire

// ==== hw/rv_de_top.sv ====
`default_nettype none

module rv_de_top (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              inst_valid_i,
    input  rv_pkg::word_t     inst_i,
    input  rv_pkg::word_t     pc_i,
    output logic              ex_valid_o,
    output rv_pkg::word_t     ex_pc_o,
    output rv_pkg::reg_addr_t ex_rd_o,
    output logic              ex_reg_write_o,
    output rv_pkg::word_t     ex_result_o,
    output logic              ex_mem_read_o,
    output logic              ex_mem_write_o,
    output rv_pkg::word_t     ex_mem_addr_o,
    output rv_pkg::word_t     ex_store_data_o,
    output logic              ex_redirect_o,
    output rv_pkg::word_t     ex_target_o
);
    import rv_pkg::*;

    logic      dec_valid, dec_src1, dec_src2, dec_rw, dec_mrd, dec_mwr, dec_br, dec_jmp;
    opcode_e   dec_opcode, de_opcode;
    logic [2:0] dec_funct3, de_funct3;
    alu_op_e   dec_alu_op, de_alu_op;
    wb_sel_e   dec_wb_sel, de_wb_sel;
    reg_addr_t dec_rs1, dec_rs2, dec_rd, de_rd;
    word_t     dec_offset, rf_rdata1, rf_rdata2, de_rdata1, de_rdata2, de_offset;
    logic      de_src1, de_src2, de_rw, de_mrd, de_mwr, de_br, de_jmp;

    inst_decoder u_dec (
        .inst_valid_i(inst_valid_i), .inst_i(inst_i), .valid_o(dec_valid),
        .opcode_o(dec_opcode), .funct3_o(dec_funct3), .alu_op_o(dec_alu_op),
        .alu_src1_o(dec_src1), .alu_src2_o(dec_src2), .wb_sel_o(dec_wb_sel),
        .reg_write_o(dec_rw), .mem_read_o(dec_mrd), .mem_write_o(dec_mwr),
        .branch_o(dec_br), .jump_o(dec_jmp), .rs1_o(dec_rs1), .rs2_o(dec_rs2),
        .rd_o(dec_rd), .offset_o(dec_offset)
    );

    reg_file u_rf (
        .clk(clk), .arst_n_i(arst_n_i), .rs1_i(dec_rs1), .rs2_i(dec_rs2),
        .rd_i(ex_rd_o), .we_i(ex_reg_write_o), .wdata_i(ex_result_o), // writeback from execute
        .rdata1_o(rf_rdata1), .rdata2_o(rf_rdata2)
    );

    decode_execute_register u_de (
        .clk(clk), .arst_n_i(arst_n_i), .flush_i(ex_redirect_o), // squash wrong-path slot
        .valid_i(dec_valid), .pc_i(pc_i), .opcode_i(dec_opcode), .funct3_i(dec_funct3),
        .alu_op_i(dec_alu_op), .alu_src1_i(dec_src1), .alu_src2_i(dec_src2),
        .wb_sel_i(dec_wb_sel), .reg_write_i(dec_rw), .mem_read_i(dec_mrd),
        .mem_write_i(dec_mwr), .branch_i(dec_br), .jump_i(dec_jmp), .rs1_i(dec_rs1),
        .rs2_i(dec_rs2), .rd_i(dec_rd), .read_data1_i(rf_rdata1),
        .read_data2_i(rf_rdata2), .offset_i(dec_offset),
        .de_valid_o(ex_valid_o), .de_pc_o(ex_pc_o), .de_opcode_o(de_opcode),
        .de_funct3_o(de_funct3), .de_alu_op_o(de_alu_op), .de_alu_src1_o(de_src1),
        .de_alu_src2_o(de_src2), .de_wb_sel_o(de_wb_sel), .de_reg_write_o(de_rw),
        .de_mem_read_o(de_mrd), .de_mem_write_o(de_mwr), .de_branch_o(de_br),
        .de_jump_o(de_jmp), .de_rs1_o(), .de_rs2_o(), .de_rd_o(de_rd),
        .de_read_data1_o(de_rdata1), .de_read_data2_o(de_rdata2), .de_offset_o(de_offset)
    );

    execute_unit u_ex (
        .de_valid_i(ex_valid_o), .de_pc_i(ex_pc_o), .de_opcode_i(de_opcode),
        .de_funct3_i(de_funct3), .de_alu_op_i(de_alu_op), .de_alu_src1_i(de_src1),
        .de_alu_src2_i(de_src2), .de_wb_sel_i(de_wb_sel), .de_reg_write_i(de_rw),
        .de_mem_read_i(de_mrd), .de_mem_write_i(de_mwr), .de_branch_i(de_br),
        .de_jump_i(de_jmp), .de_rd_i(de_rd), .de_read_data1_i(de_rdata1),
        .de_read_data2_i(de_rdata2), .de_offset_i(de_offset),
        .result_o(ex_result_o), .rf_we_o(ex_reg_write_o), .rf_waddr_o(ex_rd_o),
        .mem_read_o(ex_mem_read_o), .mem_write_o(ex_mem_write_o),
        .mem_addr_o(ex_mem_addr_o), .store_data_o(ex_store_data_o),
        .redirect_o(ex_redirect_o), .target_o(ex_target_o)
    );

endmodule

`default_nettype wire

// ==== verification/rv_de_chk.sv ====
`default_nettype none

module rv_de_chk (
    input logic clk,
    input logic arst_n_i,
    input logic valid_i,
    input logic reg_write_i,
    input logic mem_read_i,
    input logic mem_write_i,
    input logic redirect_i
);

    // a bubble in execute has no side effects
    idle_quiet: assert property (@(posedge clk) disable iff (!arst_n_i)
        !valid_i |-> !(mem_read_i || mem_write_i || redirect_i || reg_write_i))
        else $error("strobe active while execute holds no valid instruction");

    one_mem_strobe: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(mem_read_i && mem_write_i))
        else $error("memory read and write requested together");

    // wrong-path slot must be squashed
    squash_after_redirect: assert property (@(posedge clk) disable iff (!arst_n_i)
        redirect_i |=> !valid_i)
        else $error("instruction after a redirect was not squashed");

endmodule

bind rv_de_top rv_de_chk chk0 (
    .clk(clk), .arst_n_i(arst_n_i), .valid_i(ex_valid_o),
    .reg_write_i(ex_reg_write_o), .mem_read_i(ex_mem_read_o),
    .mem_write_i(ex_mem_write_o), .redirect_i(ex_redirect_o)
);

`default_nettype wire

// ==== verification/rv_de_tb.sv ====
`default_nettype none

module rv_de_tb;
    import rv_pkg::*;

    logic      clk;
    logic      arst_n_i;
    logic      inst_valid_i;
    word_t     inst_i;
    word_t     pc_i;
    logic      ex_valid_o, ex_reg_write_o, ex_mem_read_o, ex_mem_write_o, ex_redirect_o;
    word_t     ex_pc_o, ex_result_o, ex_mem_addr_o, ex_store_data_o, ex_target_o;
    reg_addr_t ex_rd_o;
    word_t     ref_regs [32]; // architectural model, x0 never written
    word_t     cur_pc;        // fetch side pc
    word_t     last_pc;       // pc of the instruction now in execute
    int        issued, errors, failed_tests;

    rv_de_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // period 20
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    function automatic word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                    input reg_addr_t rd, input reg_addr_t rs1,
                                    input reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                    input reg_addr_t rd, input reg_addr_t rs1,
                                    input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_s(input reg_addr_t rs1, input reg_addr_t rs2,
                                    input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE}; // sw
    endfunction

    function automatic word_t enc_b(input logic [2:0] f3, input reg_addr_t rs1,
                                    input reg_addr_t rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic word_t enc_u(input logic [6:0] opc, input reg_addr_t rd,
                                    input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic word_t enc_j(input reg_addr_t rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    // rv32i integer semantics, alt selects sub / sra
    function automatic word_t model_alu(input logic [2:0] f3, input logic alt,
                                        input word_t a, input word_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic model_taken(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic longint time_budget();
        return longint'(issued) * 40 + 2000; // 40 per instruction plus slack
    endfunction

    // called on a falling edge, returns one cycle later with execute visible
    task automatic issue(input word_t inst);
        inst_valid_i = 1'b1;
        inst_i       = inst;
        pc_i         = cur_pc;
        last_pc      = cur_pc;
        cur_pc       = cur_pc + 32'd4;
        issued++;
        @(negedge clk);
        inst_valid_i = 1'b0;
        inst_i       = '0;
    endtask

    task automatic expect_write(input reg_addr_t rd, input word_t exp, input logic redirect);
        check_bit("ex_valid_o", ex_valid_o, 1'b1);
        check_word("ex_pc_o", ex_pc_o, last_pc);
        check_reg("ex_rd_o", ex_rd_o, rd);
        check_bit("ex_reg_write_o", ex_reg_write_o, rd != 5'd0); // x0 never written
        check_word("ex_result_o", ex_result_o, exp);
        check_bit("ex_redirect_o", ex_redirect_o, redirect);
        check_bit("ex_mem_read_o", ex_mem_read_o, 1'b0);
        check_bit("ex_mem_write_o", ex_mem_write_o, 1'b0);
        if (rd != 5'd0) begin
            ref_regs[rd] = exp;
        end
    endtask

    task automatic check_mem(input logic is_load, input word_t addr);
        check_bit("ex_valid_o", ex_valid_o, 1'b1);
        check_bit("ex_mem_read_o", ex_mem_read_o, is_load);
        check_bit("ex_mem_write_o", ex_mem_write_o, !is_load);
        check_bit("ex_reg_write_o", ex_reg_write_o, 1'b0);
        check_bit("ex_redirect_o", ex_redirect_o, 1'b0);
        check_word("ex_mem_addr_o", ex_mem_addr_o, addr);
    endtask

    task automatic load_reg(input reg_addr_t rd, input word_t val);
        word_t hi;
        hi = val + 32'h800; // low part is sign-extended by addi
        issue(enc_u(OPC_LUI, rd, hi[31:12]));
        expect_write(rd, {hi[31:12], 12'b0}, 1'b0);
        issue(enc_i(OPC_OP_IMM, 3'b000, rd, rd, val[11:0])); // reads lui result via bypass
        expect_write(rd, val, 1'b0);
    endtask

    // wrong-path slot right behind a redirect, then fetch from the target
    task automatic follow_redirect(input word_t target);
        issue(enc_i(OPC_OP_IMM, 3'b000, 5'd3, 5'd3, 12'h001));
        check_bit("ex_valid_o", ex_valid_o, 1'b0);
        check_bit("ex_reg_write_o", ex_reg_write_o, 1'b0);
        cur_pc = target;
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: %0d errors", name, errors - errs_before);
        end
    endtask

    task automatic test_idle();
        int    e0;
        word_t junk [4];
        e0 = errors;
        junk[0] = enc_i(OPC_OP_IMM, 3'b000, 5'd7, 5'd0, 12'h055);
        junk[1] = enc_i(OPC_LOAD, 3'b010, 5'd7, 5'd0, 12'h010);
        junk[2] = enc_s(5'd0, 5'd7, 12'h020);
        junk[3] = enc_j(5'd7, 21'h000100);
        foreach (junk[i]) begin
            inst_i = junk[i]; // legal word with the strobe low
            @(negedge clk);
            check_bit("ex_valid_o", ex_valid_o, 1'b0);
            check_bit("ex_reg_write_o", ex_reg_write_o, 1'b0);
            check_bit("ex_mem_read_o", ex_mem_read_o, 1'b0);
            check_bit("ex_mem_write_o", ex_mem_write_o, 1'b0);
            check_bit("ex_redirect_o", ex_redirect_o, 1'b0);
        end
        inst_i = '0;
        report_test("reset_idle", e0);
    endtask

    task automatic test_alu_random();
        int          e0;
        reg_addr_t   rd, rs1, rs2;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        logic [19:0] upper;
        e0 = errors;
        for (int r = 1; r < 32; r++) begin
            load_reg(reg_addr_t'(r), $urandom());
        end
        repeat (60) begin
            rd    = reg_addr_t'($urandom()); // x0 now and then
            rs1   = reg_addr_t'($urandom());
            rs2   = reg_addr_t'($urandom());
            f3    = 3'($urandom());
            alt   = 1'($urandom()) && (f3 == 3'd0 || f3 == 3'd5);
            imm   = 12'($urandom());
            upper = 20'($urandom());
            case ($urandom_range(3, 0))
                0: begin
                    issue(enc_r({1'b0, alt, 5'b0}, f3, rd, rs1, rs2));
                    expect_write(rd, model_alu(f3, alt, ref_regs[rs1], ref_regs[rs2]), 1'b0);
                end
                1: begin
                    if (f3 == 3'd1 || f3 == 3'd5) begin
                        imm = {1'b0, alt, 5'b0, imm[4:0]}; // shamt form
                    end
                    issue(enc_i(OPC_OP_IMM, f3, rd, rs1, imm));
                    expect_write(rd, model_alu(f3, f3 == 3'd5 && alt, ref_regs[rs1],
                                               {{20{imm[11]}}, imm}), 1'b0);
                end
                2: begin
                    issue(enc_u(OPC_LUI, rd, upper));
                    expect_write(rd, {upper, 12'b0}, 1'b0);
                end
                default: begin
                    issue(enc_u(OPC_AUIPC, rd, upper));
                    expect_write(rd, last_pc + {upper, 12'b0}, 1'b0);
                end
            endcase
        end
        issue(enc_i(OPC_OP_IMM, 3'b000, 5'd0, 5'd1, 12'h123)); // dropped write to x0
        expect_write(5'd0, ref_regs[1] + 32'h123, 1'b0);
        issue(enc_r(7'b0, 3'b110, 5'd5, 5'd0, 5'd0));
        expect_write(5'd5, 32'd0, 1'b0);
        report_test("alu_random", e0);
    endtask

    task automatic test_bypass_chain();
        int          e0;
        word_t       acc;
        logic [11:0] step;
        e0 = errors;
        issue(enc_i(OPC_OP_IMM, 3'b000, 5'd10, 5'd0, 12'd5));
        expect_write(5'd10, 32'd5, 1'b0);
        acc = 32'd5;
        repeat (12) begin
            step = 12'($urandom());
            acc  = acc + {{20{step[11]}}, step};
            issue(enc_i(OPC_OP_IMM, 3'b000, 5'd10, 5'd10, step));
            expect_write(5'd10, acc, 1'b0);
        end
        issue(enc_r(7'b0, 3'b000, 5'd11, 5'd10, 5'd10)); // both ports bypassed
        expect_write(5'd11, acc + acc, 1'b0);
        report_test("bypass_chain", e0);
    endtask

    task automatic test_branches();
        int          e0;
        logic [12:0] off;
        logic        taken;
        word_t       target;
        br_cond_e    conds [6] = '{BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU};
        word_t       vals_a [3] = '{32'd7, 32'hFFFF_FFFB, 32'd3};
        word_t       vals_b [3] = '{32'd7, 32'd3, 32'hFFFF_FFFB};
        e0 = errors;
        foreach (conds[c]) begin
            for (int p = 0; p < 3; p++) begin
                load_reg(5'd1, vals_a[p]);
                load_reg(5'd2, vals_b[p]);
                off   = 13'($urandom()) & 13'h1FFE;
                taken = model_taken(conds[c], vals_a[p], vals_b[p]);
                issue(enc_b(conds[c], 5'd1, 5'd2, off));
                target = last_pc + {{19{off[12]}}, off};
                check_bit("ex_valid_o", ex_valid_o, 1'b1);
                check_bit("ex_reg_write_o", ex_reg_write_o, 1'b0);
                check_bit("ex_redirect_o", ex_redirect_o, taken);
                if (taken) begin
                    check_word("ex_target_o", ex_target_o, target);
                    follow_redirect(target);
                end
            end
        end
        report_test("branches", e0);
    endtask

    task automatic test_jumps();
        int          e0;
        logic [20:0] joff;
        logic [11:0] imm;
        word_t       target;
        reg_addr_t   rd;
        e0 = errors;
        repeat (4) begin
            rd   = reg_addr_t'($urandom());
            joff = 21'($urandom()) & 21'h1F_FFFE;
            issue(enc_j(rd, joff));
            target = last_pc + {{11{joff[20]}}, joff};
            expect_write(rd, last_pc + 32'd4, 1'b1); // link value
            check_word("ex_target_o", ex_target_o, target);
            follow_redirect(target);
            load_reg(5'd6, $urandom() | 32'd1);      // odd base
            imm = 12'($urandom()) & 12'hFFE;         // even imm, so the sum stays odd
            issue(enc_i(OPC_JALR, 3'b000, rd, 5'd6, imm));
            target = (ref_regs[6] + {{20{imm[11]}}, imm}) & ~32'd1;
            expect_write(rd, last_pc + 32'd4, 1'b1);
            check_word("ex_target_o", ex_target_o, target);
            follow_redirect(target);
        end
        report_test("jumps", e0);
    endtask

    task automatic test_mem();
        int          e0;
        reg_addr_t   rs1, rs2;
        logic [11:0] imm;
        word_t       addr;
        e0 = errors;
        repeat (8) begin
            rs1  = reg_addr_t'($urandom());
            rs2  = reg_addr_t'($urandom());
            imm  = 12'($urandom());
            addr = ref_regs[rs1] + {{20{imm[11]}}, imm};
            issue(enc_i(OPC_LOAD, 3'b010, rs2, rs1, imm)); // lw, rd must stay untouched
            check_mem(1'b1, addr);
            issue(enc_s(rs1, rs2, imm));                    // reads rs2 right after the load
            check_mem(1'b0, addr);
            check_word("ex_store_data_o", ex_store_data_o, ref_regs[rs2]);
        end
        report_test("load_store", e0);
    endtask

    initial begin
        while ($time <= time_budget()) begin
            @(posedge clk);
        end
        $display("timeout: simulation ran past its time budget");
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        void'($urandom(48));
        arst_n_i     = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        pc_i         = '0;
        cur_pc       = 32'h0000_1000;
        last_pc      = '0;
        issued       = 0;
        errors       = 0;
        failed_tests = 0;
        foreach (ref_regs[r]) begin
            ref_regs[r] = '0;
        end
        repeat (8) @(negedge clk);
        arst_n_i = 1'b1;
        test_idle();
        test_alu_random();
        test_bypass_chain();
        test_branches();
        test_jumps();
        test_mem();
        $display("summary: %0d instructions, %0d tests failed, %0d errors",
                 issued, failed_tests, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rv_de_slice.f ====
hw/rv_pkg.sv
hw/inst_decoder.sv
hw/reg_file.sv
hw/decode_execute_register.sv
hw/execute_unit.sv
hw/rv_de_top.sv
verification/rv_de_chk.sv
verification/rv_de_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := rv_de_tb
FILELIST  := rv_de_slice.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "SOME TESTS FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
